/* core_pkg.sv */
package core_pkg;

  localparam int DATA_WIDTH  = 32;
  localparam int INSTR_WIDTH = 32;
  localparam int REG_COUNT   = 32;

  // The source starts with IN_DEPTH credits and decode starts with QUEUE_DEPTH credits.
  localparam int IN_DEPTH    = 2;
  localparam int QUEUE_DEPTH = 4;

  localparam int REG_IDX_WIDTH = $clog2(REG_COUNT);
  localparam int OPCODE_WIDTH  = 4;

  // The immediate fills whatever the three register fields and the opcode leave free.
  localparam int IMM_WIDTH = INSTR_WIDTH - 3 * REG_IDX_WIDTH - OPCODE_WIDTH;

  localparam int IN_PTR_WIDTH = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int Q_PTR_WIDTH  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

  typedef logic [DATA_WIDTH-1:0]    data_t;
  typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
  typedef logic [IMM_WIDTH-1:0]     imm_t;

  typedef logic [$clog2(IN_DEPTH+1)-1:0]    in_cnt_t;
  typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] q_cnt_t;
  typedef logic [IN_PTR_WIDTH-1:0]          in_ptr_t;
  typedef logic [Q_PTR_WIDTH-1:0]           q_ptr_t;

  // Codes not listed here decode as no-ops.
  typedef enum logic [OPCODE_WIDTH-1:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_SLT  = 4'd6,
    OP_ADDI = 4'd7
  } opcode_e;

  typedef struct packed {
    imm_t     imm;
    reg_idx_t rd;
    reg_idx_t ra;
    reg_idx_t rb;
    opcode_e  opcode;
  } instr_t;

  typedef struct packed {
    opcode_e  opcode;
    reg_idx_t rd;
    logic     we;
    data_t    a;
    data_t    b;
    data_t    imm;
  } issue_t;

  typedef struct packed {
    reg_idx_t rd;
    data_t    data;
  } wb_t;

endpackage : core_pkg

/* regfile.sv */
`timescale 1ns/1ps

module regfile import core_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  reg_idx_t rd_a_idx_i,
  input  reg_idx_t rd_b_idx_i,
  output data_t    rd_a_data_o,
  output data_t    rd_b_data_o,
  input  logic     wr_valid_i,
  input  wb_t      wr_i
);

  data_t regs [REG_COUNT];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_valid_i && (wr_i.rd != '0)) begin
      regs[wr_i.rd] <= wr_i.data;
    end
  end

  // Register 0 is hardwired to zero.
  // There is no bypass, so a write shows up on the read ports one cycle later.
  assign rd_a_data_o = (rd_a_idx_i == '0) ? '0 : regs[rd_a_idx_i];
  assign rd_b_data_o = (rd_b_idx_i == '0) ? '0 : regs[rd_b_idx_i];

endmodule : regfile

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     instr_valid_i,
  input  instr_t   instr_i,
  output logic     instr_credit_o,
  output reg_idx_t rd_a_idx_o,
  output reg_idx_t rd_b_idx_o,
  input  data_t    rd_a_data_i,
  input  data_t    rd_b_data_i,
  input  logic     q_credit_i,
  input  logic     wb_valid_i,
  input  wb_t      wb_i,
  output logic     issue_valid_o,
  output issue_t   issue_o
);

  instr_t  in_buf [IN_DEPTH];
  in_ptr_t in_wr_ptr;
  in_ptr_t in_rd_ptr;
  in_cnt_t in_count;

  instr_t  head;
  logic    head_valid;
  opcode_e dec_op;
  logic    is_alu;
  logic    uses_a;
  logic    uses_b;
  logic    writes_rd;
  data_t   imm_ext;

  logic [REG_COUNT-1:0] busy;
  logic [REG_COUNT-1:0] busy_d;
  q_cnt_t               q_credits;
  logic                 hazard;
  logic                 issue;

  assign head       = in_buf[in_rd_ptr];
  assign head_valid = (in_count != '0);

  // Only the oldest buffered instruction is decoded, so issue stays in program order.
  always_comb begin
    dec_op = head.opcode;
    is_alu = 1'b0;
    uses_a = 1'b0;
    uses_b = 1'b0;
    case (head.opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: begin
        is_alu = 1'b1;
        uses_a = 1'b1;
        uses_b = 1'b1;
      end
      OP_ADDI: begin
        is_alu = 1'b1;
        uses_a = 1'b1;
      end
      default: dec_op = OP_NOP;
    endcase
  end

  assign writes_rd = is_alu && (head.rd != '0);
  assign imm_ext   = {{(DATA_WIDTH-IMM_WIDTH){head.imm[IMM_WIDTH-1]}}, head.imm};

  assign rd_a_idx_o = head.ra;
  assign rd_b_idx_o = head.rb;

  // Hold back the head while any register it touches still waits for a write-back.
  assign hazard = (uses_a && busy[head.ra]) ||
                  (uses_b && busy[head.rb]) ||
                  (writes_rd && busy[head.rd]);
  assign issue  = head_valid && (q_credits != '0) && !hazard;

  // A write-back and an issue never name the same register in one cycle,
  // because issue requires rd to be idle.
  always_comb begin
    busy_d = busy;
    if (wb_valid_i) begin
      busy_d[wb_i.rd] = 1'b0;
    end
    if (issue && writes_rd) begin
      busy_d[head.rd] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      in_wr_ptr      <= '0;
      in_rd_ptr      <= '0;
      in_count       <= '0;
      busy           <= '0;
      q_credits      <= q_cnt_t'(QUEUE_DEPTH);
      instr_credit_o <= 1'b0;
      issue_valid_o  <= 1'b0;
    end else begin
      if (instr_valid_i) begin
        in_wr_ptr <= (in_wr_ptr == in_ptr_t'(IN_DEPTH-1)) ? '0 : in_wr_ptr + 1'b1;
      end
      if (issue) begin
        in_rd_ptr <= (in_rd_ptr == in_ptr_t'(IN_DEPTH-1)) ? '0 : in_rd_ptr + 1'b1;
      end
      in_count <= in_count + in_cnt_t'(instr_valid_i) - in_cnt_t'(issue);

      case ({issue, q_credit_i})
        2'b10:   q_credits <= q_credits - 1'b1;
        2'b01:   q_credits <= q_credits + 1'b1;
        default: q_credits <= q_credits;
      endcase

      busy           <= busy_d;
      instr_credit_o <= issue;
      issue_valid_o  <= issue;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      in_buf[in_wr_ptr] <= instr_i;
    end
    if (issue) begin
      issue_o.opcode <= dec_op;
      issue_o.rd     <= head.rd;
      issue_o.we     <= writes_rd;
      issue_o.a      <= rd_a_data_i;
      issue_o.b      <= rd_b_data_i;
      issue_o.imm    <= imm_ext;
    end
  end

endmodule : decode_stage

/* issue_queue.sv */
`timescale 1ns/1ps

module issue_queue import core_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   push_i,
  input  issue_t push_data_i,
  input  logic   pop_i,
  output logic   head_valid_o,
  output issue_t head_o,
  output logic   credit_o
);

  issue_t mem [QUEUE_DEPTH];
  q_ptr_t wr_ptr;
  q_ptr_t rd_ptr;
  q_cnt_t count;
  logic   pop_ok;

  assign head_valid_o = (count != '0);
  assign head_o       = mem[rd_ptr];

  // A pop on an empty queue is ignored.
  assign pop_ok = pop_i && head_valid_o;

  // Pushes need no full check. The producer only pushes while it holds a credit.
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr <= (wr_ptr == q_ptr_t'(QUEUE_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == q_ptr_t'(QUEUE_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      count    <= count + q_cnt_t'(push_i) - q_cnt_t'(pop_ok);
      // Each released entry hands one credit back to decode.
      credit_o <= pop_ok;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

endmodule : issue_queue

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   halt_i,
  input  logic   head_valid_i,
  input  issue_t head_i,
  output logic   pop_o,
  output logic   wb_valid_o,
  output wb_t    wb_o
);

  data_t result;

  assign pop_o = head_valid_i && !halt_i;

  always_comb begin
    case (head_i.opcode)
      OP_ADD:  result = head_i.a + head_i.b;
      OP_SUB:  result = head_i.a - head_i.b;
      OP_AND:  result = head_i.a & head_i.b;
      OP_OR:   result = head_i.a | head_i.b;
      OP_XOR:  result = head_i.a ^ head_i.b;
      OP_SLT:  result = data_t'($signed(head_i.a) < $signed(head_i.b));
      OP_ADDI: result = head_i.a + head_i.imm;
      default: result = '0;
    endcase
  end

  // A popped no-op frees its queue slot without producing a write-back.
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= pop_o && head_i.we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      wb_o.rd   <= head_i.rd;
      wb_o.data <= result;
    end
  end

endmodule : execute_stage

/* decode_execute_core.sv */
`timescale 1ns/1ps

module decode_execute_core import core_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   instr_valid_i,
  input  instr_t instr_i,
  output logic   instr_credit_o,
  input  logic   halt_i,
  output logic   wb_valid_o,
  output wb_t    wb_o
);

  reg_idx_t rd_a_idx;
  reg_idx_t rd_b_idx;
  data_t    rd_a_data;
  data_t    rd_b_data;

  logic     issue_valid;
  issue_t   issue;
  logic     q_credit;

  logic     head_valid;
  issue_t   head;
  logic     pop;

  regfile regfile_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rd_a_idx_i  (rd_a_idx),
    .rd_b_idx_i  (rd_b_idx),
    .rd_a_data_o (rd_a_data),
    .rd_b_data_o (rd_b_data),
    .wr_valid_i  (wb_valid_o),
    .wr_i        (wb_o)
  );

  decode_stage decode_stage_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_credit_o (instr_credit_o),
    .rd_a_idx_o     (rd_a_idx),
    .rd_b_idx_o     (rd_b_idx),
    .rd_a_data_i    (rd_a_data),
    .rd_b_data_i    (rd_b_data),
    .q_credit_i     (q_credit),
    .wb_valid_i     (wb_valid_o),
    .wb_i           (wb_o),
    .issue_valid_o  (issue_valid),
    .issue_o        (issue)
  );

  issue_queue issue_queue_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .push_i       (issue_valid),
    .push_data_i  (issue),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_o       (head),
    .credit_o     (q_credit)
  );

  execute_stage execute_stage_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .halt_i       (halt_i),
    .head_valid_i (head_valid),
    .head_i       (head),
    .pop_o        (pop),
    .wb_valid_o   (wb_valid_o),
    .wb_o         (wb_o)
  );

endmodule : decode_execute_core

/* tb_core.sv */
`timescale 1ns/1ps

module tb_core import core_pkg::*; ();

  localparam int CLK_PERIOD    = 100;
  localparam int RESET_CYCLES  = 16;
  localparam int RAND_COUNT    = 200;
  localparam int DIRECTED_MAX  = 60;
  localparam int HALT_LONG     = 40;
  localparam int RAND_HALT_MAX = 16;
  localparam int DRAIN_LIMIT   = 200;
  localparam int NUM_TESTS     = 6;

  // Each instruction gets 20 cycles, and every halt or drain period is added on top.
  localparam int WATCHDOG_CYCLES = (RAND_COUNT + DIRECTED_MAX) * 20 + RESET_CYCLES + HALT_LONG +
                                   RAND_COUNT * RAND_HALT_MAX + NUM_TESTS * DRAIN_LIMIT;

  logic   clk_i;
  logic   rst_i;
  logic   instr_valid_i;
  instr_t instr_i;
  logic   instr_credit_o;
  logic   halt_i;
  logic   wb_valid_o;
  wb_t    wb_o;

  data_t  ref_regs [REG_COUNT];
  wb_t    expected_wb [$];
  int     credits;
  int     halt_left;
  int     seed;
  int     error_count;
  int     checked_count;
  int     sent_count;
  int     tests_run;
  int     errors_at_start;
  int     checks_at_start;

  decode_execute_core decode_execute_core_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_credit_o (instr_credit_o),
    .halt_i         (halt_i),
    .wb_valid_o     (wb_valid_o),
    .wb_o           (wb_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not complete within %0d cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic instr_t encode(input logic [3:0] op, input int rd, input int ra,
                                    input int rb, input int imm);
    instr_t ins;
    ins.opcode = opcode_e'(op);
    ins.rd     = reg_idx_t'(rd);
    ins.ra     = reg_idx_t'(ra);
    ins.rb     = reg_idx_t'(rb);
    ins.imm    = imm_t'(imm);
    return ins;
  endfunction

  // The reference model is updated in program order as each instruction is sent.
  task automatic apply_model(input instr_t ins);
    data_t a;
    data_t b;
    data_t imm;
    data_t res;
    logic  known;
    wb_t   want;
    a     = ref_regs[ins.ra];
    b     = ref_regs[ins.rb];
    // A set top bit makes the immediate field negative, worth 2**IMM_WIDTH less than its raw value.
    imm   = data_t'(ins.imm);
    if (ins.imm[IMM_WIDTH-1]) begin
      imm = imm - (data_t'(1) << IMM_WIDTH);
    end
    res   = '0;
    known = 1'b1;
    case (ins.opcode)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_ADDI: res = a + imm;
      default: known = 1'b0;
    endcase
    if (known && ins.rd != '0) begin
      ref_regs[ins.rd] = res;
      want.rd   = ins.rd;
      want.data = res;
      expected_wb.push_back(want);
    end
  endtask

  // Wait for one falling edge, collect a returned credit, advance the halt window and
  // idle the link.
  task automatic next_cycle();
    @(negedge clk_i);
    if (instr_credit_o) begin
      assert (credits < IN_DEPTH) else begin
        error_count++;
        $display("credit returned at %0t while the source already held all %0d credits",
                 $time, IN_DEPTH);
      end
      if (credits < IN_DEPTH) begin
        credits++;
      end
    end
    halt_i = (halt_left > 0);
    if (halt_left > 0) begin
      halt_left--;
    end
    instr_valid_i = 1'b0;
  endtask

  task automatic send_instr(input instr_t ins);
    next_cycle();
    while (credits == 0) begin
      next_cycle();
    end
    instr_valid_i = 1'b1;
    instr_i       = ins;
    credits--;
    sent_count++;
    apply_model(ins);
  endtask

  task automatic random_instr(output instr_t ins);
    logic [3:0] op;
    op  = 4'({$random(seed)} % 10);
    ins = encode(op, {$random(seed)} % 8, {$random(seed)} % 8, {$random(seed)} % 8,
                 $random(seed));
  endtask

  task automatic drain_pipeline();
    int cycles;
    cycles = 0;
    while ((expected_wb.size() != 0 || credits != IN_DEPTH || halt_left != 0) &&
           cycles < DRAIN_LIMIT) begin
      next_cycle();
      cycles++;
    end
    repeat (4) next_cycle();
    assert (expected_wb.size() == 0) else begin
      error_count++;
      $display("%0d expected write-backs never arrived", expected_wb.size());
    end
    assert (credits == IN_DEPTH) else begin
      error_count++;
      $display("source holds %0d credits after draining instead of %0d", credits, IN_DEPTH);
    end
  endtask

  task automatic report_test(input string name);
    $display("test %-12s done: %0d errors, %0d write-backs checked", name,
             error_count - errors_at_start, checked_count - checks_at_start);
    errors_at_start = error_count;
    checks_at_start = checked_count;
    tests_run++;
  endtask

  // Outputs change on the rising edge, so they are compared at the falling edge.
  always @(negedge clk_i) begin : check_wb
    wb_t want;
    if (rst_i && wb_valid_o) begin
      assert (expected_wb.size() > 0) else begin
        error_count++;
        $display("write-back to register %0d at %0t arrived with none expected",
                 wb_o.rd, $time);
      end
      if (expected_wb.size() > 0) begin
        want = expected_wb.pop_front();
        checked_count++;
        assert (wb_o.rd == want.rd) else begin
          error_count++;
          $display("ERROR at %0t: wb_o.rd expected %0d, got %0d", $time, want.rd, wb_o.rd);
        end
        assert (wb_o.data == want.data) else begin
          error_count++;
          $display("ERROR at %0t: wb_o.data expected %h, got %h", $time, want.data, wb_o.data);
        end
      end
    end
  end

  always @(negedge clk_i) begin
    if (rst_i && sent_count == 0) begin
      assert (!wb_valid_o && !instr_credit_o) else begin
        error_count++;
        $display("wb_valid_o or instr_credit_o went high at %0t before any instruction was sent",
                 $time);
      end
    end
  end

  no_wb_while_halted: assert property (@(posedge clk_i) disable iff (!rst_i)
                                       halt_i |=> !wb_valid_o)
    else begin
      error_count++;
      $display("a write-back appeared at %0t while execution was halted", $time);
    end

  initial begin : stimulus
    instr_t ins;
    rst_i         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    halt_i        = 1'b0;
    credits       = IN_DEPTH;
    halt_left     = 0;
    seed          = 10;
    error_count   = 0;
    checked_count = 0;
    sent_count    = 0;
    tests_run     = 0;
    errors_at_start = 0;
    checks_at_start = 0;
    for (int i = 0; i < REG_COUNT; i++) begin
      ref_regs[i] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_i = 1'b1;

    repeat (8) next_cycle();
    report_test("reset");

    send_instr(encode(OP_ADDI, 1, 0, 0, -5));
    send_instr(encode(OP_ADDI, 2, 0, 0, 1234));
    send_instr(encode(OP_ADDI, 3, 0, 0, -4096));
    send_instr(encode(OP_ADD, 4, 1, 2, 0));
    send_instr(encode(OP_SUB, 5, 1, 2, 0));
    send_instr(encode(OP_AND, 6, 2, 3, 0));
    send_instr(encode(OP_OR, 7, 1, 3, 0));
    send_instr(encode(OP_XOR, 8, 2, 3, 0));
    send_instr(encode(OP_SLT, 9, 1, 2, 0));
    send_instr(encode(OP_SLT, 10, 2, 1, 0));
    send_instr(encode(OP_SLT, 11, 3, 1, 0));
    send_instr(encode(OP_ADDI, 12, 3, 0, 4095));
    drain_pipeline();
    report_test("arithmetic");

    send_instr(encode(OP_ADDI, 13, 13, 0, 1));
    send_instr(encode(OP_ADDI, 13, 13, 0, 7));
    send_instr(encode(OP_ADD, 13, 13, 13, 0));
    send_instr(encode(OP_SUB, 14, 13, 1, 0));
    send_instr(encode(OP_XOR, 14, 14, 13, 0));
    send_instr(encode(OP_SLT, 15, 14, 13, 0));
    send_instr(encode(OP_ADD, 16, 15, 14, 0));
    send_instr(encode(OP_ADDI, 16, 16, 0, -100));
    drain_pipeline();
    report_test("dependency");

    send_instr(encode(OP_NOP, 7, 1, 2, 0));
    send_instr(encode(4'd9, 8, 1, 2, 5));
    send_instr(encode(4'd15, 9, 2, 1, 5));
    send_instr(encode(OP_ADD, 0, 1, 2, 0));
    send_instr(encode(OP_ADDI, 0, 2, 0, 77));
    send_instr(encode(OP_ADD, 17, 0, 2, 0));
    send_instr(encode(OP_ADDI, 18, 0, 0, 3));
    drain_pipeline();
    report_test("noop_r0");

    halt_left = HALT_LONG;
    for (int i = 0; i < 12; i++) begin
      send_instr(encode(OP_ADDI, 19 + (i % 6), 19 + ((i + 5) % 6), 0, i * 37 - 200));
    end
    drain_pipeline();
    report_test("halt_credit");

    for (int i = 0; i < RAND_COUNT; i++) begin
      if (({$random(seed)} % 16) == 0) begin
        halt_left = 1 + {$random(seed)} % RAND_HALT_MAX;
      end
      random_instr(ins);
      send_instr(ins);
    end
    drain_pipeline();
    report_test("random");

    $display("summary: %0d tests, %0d instructions sent, %0d write-backs checked, %0d errors",
             tests_run, sent_count, checked_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : tb_core

/* all.f */
core_pkg.sv
regfile.sv
decode_stage.sv
issue_queue.sv
execute_stage.sv
decode_execute_core.sv
tb_core.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f all.f \
  --top-module tb_core \
  -o tb_core_sim

./obj_dir/tb_core_sim | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
